// ==== Makefile ====
# Verilator build for the ESDI PHY testbench

VERILATOR  ?= verilator
TOP        := esdi_phy_tb
FILELIST   := files.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# A $fatal in the testbench gives a non-zero exit status
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/esdi_phy_checker.sv ====
// ----------------------------------------------------------------------
// Concurrent assertions on the ESDI PHY top-level outputs
// Status consistency, legal tx pairs, single-cycle pulses, reset state
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module esdi_phy_checker (
    input wire                                  clk,
    input wire                                  reset,
    input wire esdi_cable_pkg::esdi_tx_pairs_t  tx,
    input wire                                  read_data,
    input wire                                  read_clk,
    input wire                                  samk_pulse,
    input wire                                  index_pulse,
    input wire esdi_phy_pkg::esdi_status_t      status
);

    // Strobe only ever comes out of the locked state
    valid_needs_lock: assert property (@(posedge clk) disable iff (reset)
        status.data_valid |-> status.clock_locked)
        else $error("data_valid high while clock_locked is low");

    // A driven pair is complementary, an idle pair is all low
    tx_pairs_legal: assert property (@(posedge clk) disable iff (reset)
        !(tx.write_data.p && tx.write_data.n) && !(tx.write_clk.p && tx.write_clk.n))
        else $error("transmit pair with both lines high");

    samk_one_cycle: assert property (@(posedge clk) disable iff (reset)
        samk_pulse |=> !samk_pulse)
        else $error("samk_pulse high for two cycles");

    index_one_cycle: assert property (@(posedge clk) disable iff (reset)
        index_pulse |=> !index_pulse)
        else $error("index_pulse high for two cycles");

    // First edge after reset release sees the cleared outputs
    reset_clears: assert property (@(posedge clk) $fell(reset) |->
        (status == '0 && tx == '0 && !read_data && !read_clk && !samk_pulse && !index_pulse))
        else $error("outputs not cleared by reset");

endmodule

`default_nettype wire

// ==== dv/esdi_phy_tb.sv ====
// ----------------------------------------------------------------------
// ESDI PHY testbench
// Receiver latency, lock table per rate, data strobe, disable, transmitter
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module esdi_phy_tb;

    // Stimulus table row
    typedef struct packed {
        esdi_cable_pkg::esdi_rate_e rate;
        logic [7:0]                 half;     // Read clock half interval in clocks
        logic                       lock;     // Lock expected
    } row_t;

    logic                           clk;
    logic                           reset;
    logic                           phy_enable;
    logic                           write_enable;
    esdi_cable_pkg::esdi_rate_e     data_rate;
    esdi_cable_pkg::esdi_rx_pairs_t rx;
    logic                           write_data_in;
    logic                           write_clk_in;
    esdi_cable_pkg::esdi_tx_pairs_t tx;
    logic                           read_data;
    logic                           read_clk;
    logic                           samk_pulse;
    logic                           index_pulse;
    esdi_phy_pkg::esdi_status_t     status;

    row_t rows [4];
    int   seed = 75;
    int   rnd;
    int   half;                         // Active half interval
    int   phase;                        // Clocks since last read clock toggle
    logic clk_run;                      // Read clock toggling
    logic clk_lvl;
    logic cur_data;                     // Bit driven for the current interval
    logic wd [16];                      // Write bit table
    logic wc [16];

    esdi_phy u_esdi_phy (
        .clk           (clk),
        .reset         (reset),
        .phy_enable    (phy_enable),
        .write_enable  (write_enable),
        .data_rate     (data_rate),
        .rx            (rx),
        .write_data_in (write_data_in),
        .write_clk_in  (write_clk_in),
        .tx            (tx),
        .read_data     (read_data),
        .read_clk      (read_clk),
        .samk_pulse    (samk_pulse),
        .index_pulse   (index_pulse),
        .status        (status)
    );

    bind esdi_phy esdi_phy_checker u_checker (
        .clk         (clk),
        .reset       (reset),
        .tx          (tx),
        .read_data   (read_data),
        .read_clk    (read_clk),
        .samk_pulse  (samk_pulse),
        .index_pulse (index_pulse),
        .status      (status)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;         // 40 ns period
    end

    // ------------------------------------------------------------------
    // Helpers and compare tasks
    // ------------------------------------------------------------------
    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            stop_with_failure($sformatf("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp));
    endtask

    task automatic check_status(input string name, input esdi_phy_pkg::esdi_status_t got,
                                input esdi_phy_pkg::esdi_status_t exp);
        if (got !== exp)
            stop_with_failure($sformatf("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp));
    endtask

    task automatic check_tx(input string name, input esdi_cable_pkg::esdi_tx_pairs_t got,
                            input esdi_cable_pkg::esdi_tx_pairs_t exp);
        if (got !== exp)
            stop_with_failure($sformatf("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp));
    endtask

    // P line carries the level and N its complement
    function automatic esdi_cable_pkg::esdi_diff_pair_t to_pair(input logic v);
        esdi_cable_pkg::esdi_diff_pair_t pr;
        pr.p = v;
        pr.n = ~v;
        return pr;
    endfunction

    function automatic esdi_cable_pkg::esdi_tx_pairs_t tx_expect(input logic d, input logic c);
        esdi_cable_pkg::esdi_tx_pairs_t t;
        t.write_data = to_pair(d);
        t.write_clk  = to_pair(c);
        return t;
    endfunction

    task automatic drive_pair(input int which, input logic v);
        case (which)
            0:       rx.read_data = to_pair(v);
            1:       rx.read_clk  = to_pair(v);
            2:       rx.samk      = to_pair(v);
            default: rx.index     = to_pair(v);
        endcase
    endtask

    function automatic logic rx_out(input int which);
        case (which)
            0:       return read_data;
            1:       return read_clk;
            2:       return samk_pulse;
            default: return index_pulse;
        endcase
    endfunction

    // Advance one clock and toggle read clock and data each half interval
    task automatic advance_cycle();
        @(negedge clk);
        if (clk_run) begin
            phase++;
            if (phase >= half) begin
                phase    = 0;
                clk_lvl  = ~clk_lvl;
                rnd      = $random(seed);
                cur_data = rnd[0];
                rx.read_clk  = to_pair(clk_lvl);
                rx.read_data = to_pair(cur_data);
            end
        end
    endtask

    task automatic wait_lock(input logic want, input int limit);
        int n;
        n = 0;
        while (status.clock_locked !== want) begin
            if (n >= limit) begin
                stop_with_failure($sformatf(
                    "Timeout: clock_locked did not become %0d within %0d cycles", want, limit));
            end else begin
                advance_cycle();
                n++;
            end
        end
    endtask

    // Level outputs rise after 5 clocks and pulse outputs give one cycle
    task automatic rx_latency(input int which, input string name);
        int k;
        drive_pair(which, 1'b1);
        for (k = 1; k <= 6; k++) begin
            @(negedge clk);
            check_bit(name, rx_out(which), (which < 2) ? (k >= 5) : (k == 5));
        end
        drive_pair(which, 1'b0);
        for (k = 1; k <= 6; k++) begin
            @(negedge clk);
            check_bit(name, rx_out(which), (which < 2) ? (k < 5) : 1'b0);
        end
    endtask

    // ------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------
    initial begin
        int   r;
        int   i;
        int   valid_cnt;
        row_t row;

        rows[0] = '{rate: esdi_cable_pkg::RATE_10M, half: 8'd40, lock: 1'b1};
        rows[1] = '{rate: esdi_cable_pkg::RATE_24M, half: 8'd17, lock: 1'b1};
        rows[2] = '{rate: esdi_cable_pkg::RATE_20M, half: 8'd28, lock: 1'b0};  // Off window
        rows[3] = '{rate: esdi_cable_pkg::RATE_15M, half: 8'd27, lock: 1'b1};

        reset         = 1'b1;
        phy_enable    = 1'b1;
        write_enable  = 1'b0;
        data_rate     = esdi_cable_pkg::RATE_10M;
        write_data_in = 1'b0;
        write_clk_in  = 1'b0;
        clk_run       = 1'b0;
        clk_lvl       = 1'b0;
        cur_data      = 1'b0;
        half          = 40;
        phase         = 0;
        for (i = 0; i < 4; i++)
            drive_pair(i, 1'b0);

        repeat (8) @(negedge clk);
        reset = 1'b0;
        advance_cycle();
        check_status("status", status, '0);
        check_bit("read_data", read_data, 1'b0);
        check_bit("read_clk", read_clk, 1'b0);
        check_bit("samk_pulse", samk_pulse, 1'b0);
        check_bit("index_pulse", index_pulse, 1'b0);
        check_tx("tx", tx, '0);

        rx_latency(0, "read_data");
        rx_latency(1, "read_clk");
        rx_latency(2, "samk_pulse");
        rx_latency(3, "index_pulse");

        for (r = 0; r < 4; r++) begin
            row = rows[r];
            clk_run    = 1'b0;          // Restart recovery from hunt
            phy_enable = 1'b0;
            advance_cycle();
            advance_cycle();
            data_rate  = row.rate;
            half       = int'(row.half);
            phase      = 0;
            phy_enable = 1'b1;
            clk_run    = 1'b1;
            if (row.lock) begin
                wait_lock(1'b1, 16 * half + 40);
                valid_cnt = 0;
                for (i = 0; i < 6 * half; i++) begin
                    advance_cycle();
                    check_bit("clock_locked", status.clock_locked, 1'b1);
                    if (status.data_valid) begin
                        check_bit("read_data", read_data, cur_data);  // Mid-interval sample
                        valid_cnt++;
                    end
                end
                if (valid_cnt < 4)
                    stop_with_failure("Too few data_valid strobes while locked");
                clk_run = 1'b0;
                if (r == 0) begin
                    // Disable while locked
                    phy_enable = 1'b0;
                    advance_cycle();
                    check_status("status", status, '0);
                    check_bit("read_data", read_data, 1'b0);
                    check_bit("read_clk", read_clk, 1'b0);
                    check_bit("samk_pulse", samk_pulse, 1'b0);
                    check_bit("index_pulse", index_pulse, 1'b0);
                end else begin
                    wait_lock(1'b0, 2 * half + 60);     // Read clock stopped
                end
            end else begin
                for (i = 0; i < 24 * half; i++) begin
                    advance_cycle();
                    check_status("status", status, '0);
                end
            end
        end

        // Transmitter echoes random write bits one cycle later
        for (i = 0; i < 16; i++) begin
            rnd   = $random(seed);
            wd[i] = rnd[0];
            wc[i] = rnd[1];
        end
        clk_run      = 1'b0;
        phy_enable   = 1'b1;
        write_enable = 1'b1;
        for (i = 0; i <= 16; i++) begin
            advance_cycle();
            if (i > 0)
                check_tx("tx", tx, tx_expect(wd[i-1], wc[i-1]));
            if (i < 16) begin
                write_data_in = wd[i];
                write_clk_in  = wc[i];
            end
        end
        write_enable  = 1'b0;
        write_data_in = 1'b1;
        write_clk_in  = 1'b1;
        for (i = 0; i < 3; i++) begin
            advance_cycle();
            check_tx("tx", tx, '0);     // Idle lines low
        end

        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
src/esdi_cable_pkg.sv
src/esdi_phy_pkg.sv
src/esdi_diff_rx.sv
src/esdi_clk_recovery.sv
src/esdi_diff_tx.sv
src/esdi_phy.sv
dv/esdi_phy_checker.sv
dv/esdi_phy_tb.sv

// ==== src/esdi_cable_pkg.sv ====
// ----------------------------------------------------------------------
// Cable-side types for the ESDI drive PHY
// Differential pair, receive and transmit pair bundles, data-rate enum
// ----------------------------------------------------------------------
`default_nettype none

package esdi_cable_pkg;

    // ------------------------------------------------------------------
    // One RS-422 style pair
    // ------------------------------------------------------------------
    typedef struct packed {
        logic p;                        // Positive line
        logic n;                        // Negative line
    } esdi_diff_pair_t;

    // Pairs arriving from the drive
    typedef struct packed {
        esdi_diff_pair_t read_data;     // NRZ read data
        esdi_diff_pair_t read_clk;      // Read reference clock
        esdi_diff_pair_t samk;          // Sector / address mark
        esdi_diff_pair_t index;         // Once per revolution
    } esdi_rx_pairs_t;

    // Pairs driven toward the drive
    typedef struct packed {
        esdi_diff_pair_t write_data;    // NRZ write data
        esdi_diff_pair_t write_clk;     // Write clock
    } esdi_tx_pairs_t;

    // ------------------------------------------------------------------
    // Data rate select indexing the period table
    // ------------------------------------------------------------------
    typedef enum logic [1:0] {
        RATE_10M = 2'd0,
        RATE_15M = 2'd1,
        RATE_20M = 2'd2,
        RATE_24M = 2'd3
    } esdi_rate_e;

endpackage

`default_nettype wire

// ==== src/esdi_clk_recovery.sv ====
// ----------------------------------------------------------------------
// Read reference clock recovery
// Hunt / locking / locked FSM and mid-interval data strobe
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module esdi_clk_recovery (
    input  wire                        clk,
    input  wire                        reset,
    input  wire                        enable,
    input  wire esdi_cable_pkg::esdi_rate_e rate,
    input  wire                        ref_level,   // Synchronized read clock
    output esdi_phy_pkg::esdi_status_t status
);

    esdi_phy_pkg::clk_rec_state_e state;

    logic                              ref_prev;
    logic                              ref_edge;
    logic [esdi_phy_pkg::PERIOD_W-1:0] interval_cnt;  // Clocks since last edge
    logic [esdi_phy_pkg::PERIOD_W-1:0] period_rec;    // Last good interval
    logic [esdi_phy_pkg::PERIOD_W-1:0] sample_point;
    logic [esdi_phy_pkg::PERIOD_W-1:0] sample_cnt;
    logic [esdi_phy_pkg::PERIOD_W-1:0] streak;        // Good intervals in a row
    logic [esdi_phy_pkg::PERIOD_W-1:0] expected;
    logic                              in_lock_win;
    logic                              in_track_win;
    logic                              timed_out;

    // ------------------------------------------------------------------
    // Edge detect and interval windows
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            ref_prev <= 1'b0;
        end else begin
            ref_prev <= ref_level;
        end
    end

    assign ref_edge = ref_level ^ ref_prev;      // Either polarity
    assign expected = esdi_phy_pkg::EXPECTED_PERIOD[rate];

    assign in_lock_win  = (interval_cnt >= expected - esdi_phy_pkg::LOCK_TOL) &&
                          (interval_cnt <= expected + esdi_phy_pkg::LOCK_TOL);
    assign in_track_win = (interval_cnt >= period_rec - esdi_phy_pkg::TRACK_TOL) &&
                          (interval_cnt <= period_rec + esdi_phy_pkg::TRACK_TOL);
    assign timed_out    = interval_cnt > expected + esdi_phy_pkg::HUNT_TIMEOUT;

    // ------------------------------------------------------------------
    // Recovery FSM
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= esdi_phy_pkg::CLK_HUNT;
            interval_cnt <= '0;
            period_rec   <= esdi_phy_pkg::RESET_PERIOD;
            sample_point <= esdi_phy_pkg::RESET_PERIOD >> 1;
            sample_cnt   <= '0;
            streak       <= '0;
            status       <= '0;
        end else if (!enable) begin
            state  <= esdi_phy_pkg::CLK_HUNT;   // Start over on re-enable
            streak <= '0;
            status <= '0;
        end else begin
            case (state)
                esdi_phy_pkg::CLK_HUNT: begin
                    status <= '0;
                    streak <= '0;
                    if (ref_edge) begin
                        interval_cnt <= 8'd1;
                        sample_cnt   <= '0;
                        state        <= esdi_phy_pkg::CLK_LOCKING;
                    end
                end

                esdi_phy_pkg::CLK_LOCKING: begin
                    status.data_valid <= 1'b0;
                    interval_cnt      <= interval_cnt + 8'd1;
                    if (ref_edge) begin
                        interval_cnt <= 8'd1;
                        sample_cnt   <= '0;
                        if (in_lock_win) begin
                            streak       <= streak + 8'd1;
                            period_rec   <= interval_cnt;
                            sample_point <= interval_cnt >> 1;   // Mid interval
                            if (streak >= esdi_phy_pkg::LOCK_STREAK) begin
                                state               <= esdi_phy_pkg::CLK_LOCKED;
                                status.clock_locked <= 1'b1;
                                streak              <= '0;
                            end
                        end else begin
                            streak <= '0;                       // Bad interval
                        end
                    end else if (timed_out) begin
                        state  <= esdi_phy_pkg::CLK_HUNT;      // Clock went quiet
                        streak <= '0;
                    end
                end

                esdi_phy_pkg::CLK_LOCKED: begin
                    interval_cnt      <= interval_cnt + 8'd1;
                    sample_cnt        <= sample_cnt + 8'd1;
                    status.data_valid <= (sample_cnt == sample_point);
                    if (ref_edge) begin
                        interval_cnt <= 8'd1;                  // Re-sync
                        sample_cnt   <= '0;
                        if (!in_track_win) begin
                            state  <= esdi_phy_pkg::CLK_HUNT;  // Drifted out
                            status <= '0;
                        end
                    end else if (timed_out) begin
                        state  <= esdi_phy_pkg::CLK_HUNT;
                        status <= '0;
                    end
                end

                default: begin
                    state  <= esdi_phy_pkg::CLK_HUNT;
                    status <= '0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== src/esdi_diff_rx.sv ====
// ----------------------------------------------------------------------
// Differential line receiver
// Pair to bit, synchronizer, level registers, rising-edge pulse
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module esdi_diff_rx (
    input  wire                            clk,
    input  wire                            reset,
    input  wire                            enable,
    input  wire esdi_cable_pkg::esdi_diff_pair_t pair,
    output logic                           level_early,  // Level one stage ahead
    output logic                           level,
    output logic                           pulse         // High one cycle on rise
);

    logic [esdi_phy_pkg::SYNC_STAGES-1:0] sync;
    logic                                 diff_bit;

    // Only a clean P high / N low counts as a one
    assign diff_bit = pair.p & ~pair.n;

    always_ff @(posedge clk) begin
        if (reset) begin
            sync        <= '0;
            level_early <= 1'b0;
            level       <= 1'b0;
            pulse       <= 1'b0;
        end else if (enable) begin
            sync        <= {sync[esdi_phy_pkg::SYNC_STAGES-2:0], diff_bit};
            level_early <= sync[esdi_phy_pkg::SYNC_STAGES-1];
            level       <= level_early;
            // Rise already in level_early but not yet in level
            pulse       <= level_early & ~level;
        end else begin
            // Sync chain frozen while disabled
            level <= 1'b0;
            pulse <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== src/esdi_diff_tx.sv ====
// ----------------------------------------------------------------------
// Write data and write clock pair drivers
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module esdi_diff_tx (
    input  wire                            clk,
    input  wire                            reset,
    input  wire                            phy_enable,
    input  wire                            write_enable,
    input  wire                            write_data_in,
    input  wire                            write_clk_in,
    output esdi_cable_pkg::esdi_tx_pairs_t tx
);

    logic data_q;
    logic clk_q;
    logic drive_en;                     // PHY enable delayed one cycle
    logic drive;

    always_ff @(posedge clk) begin
        if (reset || !phy_enable || !write_enable) begin
            data_q <= 1'b0;
            clk_q  <= 1'b0;
        end else begin
            data_q <= write_data_in;
            clk_q  <= write_clk_in;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            drive_en <= 1'b0;
        end else begin
            drive_en <= phy_enable;
        end
    end

    // Both lines idle low when not driving
    assign drive = write_enable & drive_en;

    assign tx.write_data.p = drive &  data_q;
    assign tx.write_data.n = drive & ~data_q;
    assign tx.write_clk.p  = drive &  clk_q;
    assign tx.write_clk.n  = drive & ~clk_q;

endmodule

`default_nettype wire

// ==== src/esdi_phy.sv ====
// ----------------------------------------------------------------------
// ESDI drive-side PHY top
// Four pair receivers, read clock recovery, write pair drivers
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module esdi_phy (
    input  wire                            clk,
    input  wire                            reset,
    input  wire                            phy_enable,
    input  wire                            write_enable,
    input  wire esdi_cable_pkg::esdi_rate_e     data_rate,
    input  wire esdi_cable_pkg::esdi_rx_pairs_t rx,       // From cable
    input  wire                            write_data_in,  // From encoder
    input  wire                            write_clk_in,
    output esdi_cable_pkg::esdi_tx_pairs_t tx,             // To cable
    output logic                           read_data,
    output logic                           read_clk,
    output logic                           samk_pulse,
    output logic                           index_pulse,
    output esdi_phy_pkg::esdi_status_t     status
);

    logic clk_level_early;              // Feeds recovery one stage early

    // ------------------------------------------------------------------
    // Receivers
    // ------------------------------------------------------------------
    esdi_diff_rx u_rx_data (
        .clk         (clk),
        .reset       (reset),
        .enable      (phy_enable),
        .pair        (rx.read_data),
        .level_early (),
        .level       (read_data),
        .pulse       ()
    );

    esdi_diff_rx u_rx_clk (
        .clk         (clk),
        .reset       (reset),
        .enable      (phy_enable),
        .pair        (rx.read_clk),
        .level_early (clk_level_early),
        .level       (read_clk),
        .pulse       ()
    );

    esdi_diff_rx u_rx_samk (
        .clk         (clk),
        .reset       (reset),
        .enable      (phy_enable),
        .pair        (rx.samk),
        .level_early (),
        .level       (),
        .pulse       (samk_pulse)
    );

    esdi_diff_rx u_rx_index (
        .clk         (clk),
        .reset       (reset),
        .enable      (phy_enable),
        .pair        (rx.index),
        .level_early (),
        .level       (),
        .pulse       (index_pulse)
    );

    // ------------------------------------------------------------------
    // Clock recovery and transmitter
    // ------------------------------------------------------------------
    esdi_clk_recovery u_clk_recovery (
        .clk       (clk),
        .reset     (reset),
        .enable    (phy_enable),
        .rate      (data_rate),
        .ref_level (clk_level_early),
        .status    (status)
    );

    esdi_diff_tx u_tx (
        .clk           (clk),
        .reset         (reset),
        .phy_enable    (phy_enable),
        .write_enable  (write_enable),
        .write_data_in (write_data_in),
        .write_clk_in  (write_clk_in),
        .tx            (tx)
    );

endmodule

`default_nettype wire

// ==== src/esdi_phy_pkg.sv ====
// ----------------------------------------------------------------------
// Read clock recovery definitions
// Timing constants, recovery state enum, recovered status struct
// ----------------------------------------------------------------------
`default_nettype none

package esdi_phy_pkg;

    // ------------------------------------------------------------------
    // Widths and depths
    // ------------------------------------------------------------------
    localparam int SYNC_STAGES = 3;     // Metastability chain
    localparam int PERIOD_W    = 8;     // Interval counter width

    // Windows and limits in system clocks
    localparam logic [PERIOD_W-1:0] LOCK_TOL     = 8'd5;   // While locking
    localparam logic [PERIOD_W-1:0] TRACK_TOL    = 8'd3;   // While locked
    localparam logic [PERIOD_W-1:0] HUNT_TIMEOUT = 8'd20;  // Past expected interval
    localparam logic [PERIOD_W-1:0] LOCK_STREAK  = 8'd8;   // Good intervals before lock
    localparam logic [PERIOD_W-1:0] RESET_PERIOD = 8'd40;

    // Expected interval per rate
    // Entry order follows esdi_rate_e encoding
    localparam logic [PERIOD_W-1:0] EXPECTED_PERIOD [4] = '{
        8'd40,                          // RATE_10M
        8'd27,                          // RATE_15M
        8'd20,                          // RATE_20M
        8'd17                           // RATE_24M
    };

    // ------------------------------------------------------------------
    // Recovery FSM
    // ------------------------------------------------------------------
    typedef enum logic [1:0] {
        CLK_HUNT    = 2'd0,             // Waiting for any edge
        CLK_LOCKING = 2'd1,             // Measuring intervals
        CLK_LOCKED  = 2'd2              // Tracking, strobing data
    } clk_rec_state_e;

    // Recovered status toward the decoder
    typedef struct packed {
        logic clock_locked;
        logic data_valid;               // One cycle at mid interval
    } esdi_status_t;

endpackage

`default_nettype wire
